//--- logic/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              advance_i,
	input  logic              instr_valid_i,
	input  lsp_pkg::word_t    instr_i,
	output logic              instr_ready_o,
	output lsp_pkg::reg_idx_t raddr_a_o,
	output lsp_pkg::reg_idx_t raddr_b_o,
	input  lsp_pkg::word_t    rdata_a_i,
	input  lsp_pkg::word_t    rdata_b_i,
	stage_if.dst              ex_busy_i,
	stage_if.dst              mem_busy_i,
	input  lsp_pkg::reg_idx_t wb_rd_i,
	input  logic              wb_pending_i,
	stage_if.src              out
);

	lsp_pkg::opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	lsp_pkg::reg_idx_t rs1, rs2, rd;
	lsp_pkg::op_e op;
	lsp_pkg::wb_sel_e wb_sel;
	logic use_rs1, use_rs2, use_imm;
	lsp_pkg::word_t imm;
	logic hazard;

	assign opcode = instr_i[6:0];
	assign rd     = instr_i[11:7];
	assign funct3 = instr_i[14:12];
	assign rs1    = instr_i[19:15];
	assign rs2    = instr_i[24:20];
	assign funct7 = instr_i[31:25];

	always_comb begin
		op = lsp_pkg::op_illegal;
		imm = '0;
		case (opcode)
			lsp_pkg::opc_op: begin
				if (funct7 == 7'b0000000) begin
					case (funct3)
						3'b000: op = lsp_pkg::op_add;
						3'b100: op = lsp_pkg::op_xor;
						3'b110: op = lsp_pkg::op_or;
						3'b111: op = lsp_pkg::op_and;
						default: op = lsp_pkg::op_illegal;
					endcase
				end
				else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					op = lsp_pkg::op_sub;
				end
			end
			lsp_pkg::opc_op_imm: begin
				if (funct3 == 3'b000) op = lsp_pkg::op_addi;
				imm = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			lsp_pkg::opc_lui: begin
				op = lsp_pkg::op_lui;
				imm = {instr_i[31:12], 12'b0};
			end
			lsp_pkg::opc_load: begin
				if (funct3 == 3'b010) op = lsp_pkg::op_lw;
				imm = {{20{instr_i[31]}}, instr_i[31:20]};
			end
			lsp_pkg::opc_store: begin
				if (funct3 == 3'b010) op = lsp_pkg::op_sw;
				imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
			end
			default: op = lsp_pkg::op_illegal;
		endcase
	end

	always_comb begin
		case (op)
			lsp_pkg::op_lw: wb_sel = lsp_pkg::wb_mem;
			lsp_pkg::op_sw, lsp_pkg::op_illegal: wb_sel = lsp_pkg::wb_none;
			default: wb_sel = lsp_pkg::wb_alu;
		endcase
	end

	assign use_imm = op inside {lsp_pkg::op_addi, lsp_pkg::op_lui, lsp_pkg::op_lw, lsp_pkg::op_sw};
	assign use_rs1 = !(op inside {lsp_pkg::op_lui, lsp_pkg::op_illegal}) && rs1 != '0;
	assign use_rs2 = (op inside {lsp_pkg::op_add, lsp_pkg::op_sub, lsp_pkg::op_and,
		lsp_pkg::op_or, lsp_pkg::op_xor, lsp_pkg::op_sw}) && rs2 != '0;

	// any older writer of a source register still in flight.
	always_comb begin
		hazard = 1'b0;
		if (ex_busy_i.valid && ex_busy_i.reg_we) begin
			hazard |= (use_rs1 && rs1 == ex_busy_i.rd) || (use_rs2 && rs2 == ex_busy_i.rd);
		end
		if (mem_busy_i.valid && mem_busy_i.reg_we) begin
			hazard |= (use_rs1 && rs1 == mem_busy_i.rd) || (use_rs2 && rs2 == mem_busy_i.rd);
		end
		if (wb_pending_i) begin
			hazard |= (use_rs1 && rs1 == wb_rd_i) || (use_rs2 && rs2 == wb_rd_i);
		end
	end

	assign instr_ready_o = advance_i & ~hazard;
	assign raddr_a_o = rs1;
	assign raddr_b_o = rs2;

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (~rst_ni) begin
			out.valid  <= 1'b0;
			out.op     <= lsp_pkg::op_illegal;
			out.wb_sel <= lsp_pkg::wb_none;
			out.rd     <= '0;
			out.reg_we <= 1'b0;
		end
		else if (advance_i) begin
			out.valid  <= instr_valid_i & ~hazard; // bubble otherwise.
			out.op     <= op;
			out.wb_sel <= wb_sel;
			out.rd     <= rd;
			out.reg_we <= (wb_sel != lsp_pkg::wb_none);
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			out.a          <= (op == lsp_pkg::op_lui) ? '0 : rdata_a_i;
			out.b          <= use_imm ? imm : rdata_b_i;
			out.store_data <= rdata_b_i;
		end
	end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
	input logic  clk_i,
	input logic  rst_ni,
	input logic  advance_i,
	stage_if.dst in,
	stage_if.src out
);

	lsp_pkg::word_t result;

	// lui, addi and address generation all reduce to a + b.
	always_comb begin
		case (in.op)
			lsp_pkg::op_sub: result = in.a - in.b;
			lsp_pkg::op_and: result = in.a & in.b;
			lsp_pkg::op_or:  result = in.a | in.b;
			lsp_pkg::op_xor: result = in.a ^ in.b;
			default:         result = in.a + in.b;
		endcase
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (~rst_ni) begin
			out.valid  <= 1'b0;
			out.op     <= lsp_pkg::op_illegal;
			out.wb_sel <= lsp_pkg::wb_none;
			out.rd     <= '0;
			out.reg_we <= 1'b0;
		end
		else if (advance_i) begin
			out.valid  <= in.valid;
			out.op     <= in.op;
			out.wb_sel <= in.wb_sel;
			out.rd     <= in.rd;
			out.reg_we <= in.reg_we;
		end
	end

	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			out.a          <= result;
			out.b          <= in.b;
			out.store_data <= in.store_data;
		end
	end

endmodule

//--- logic/ls_core_top.sv
`timescale 1ns/1ns

module ls_core_top #(
	parameter int unsigned dmem_words = lsp_pkg::dmem_words_default
) (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  logic              instr_valid_i,
	input  lsp_pkg::word_t    instr_i,
	output logic              instr_ready_o,
	output logic              retire_valid_o,
	input  logic              retire_ready_i,
	output lsp_pkg::reg_idx_t retire_rd_o,
	output lsp_pkg::word_t    retire_data_o,
	output logic              retire_we_o,
	output logic              retire_illegal_o,
	input  lsp_pkg::word_t    io_sw_i,
	output lsp_pkg::word_t    io_ledr_o,
	output lsp_pkg::word_t    io_ledg_o,
	output lsp_pkg::word_t    io_hex_o,
	output lsp_pkg::word_t    ls_count_o
);

	stage_if d2e_if ();
	stage_if e2m_if ();
	stage_if m2w_if ();

	lsp_pkg::reg_idx_t raddr_a, raddr_b, rf_waddr;
	lsp_pkg::word_t rdata_a, rdata_b, rf_wdata;
	logic rf_we;
	logic advance;

	assign advance = ~retire_valid_o | retire_ready_i; // whole pipe moves together.

	reg_file u_reg_file (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.raddr_a_i(raddr_a),
		.raddr_b_i(raddr_b),
		.rdata_a_o(rdata_a),
		.rdata_b_o(rdata_b),
		.we_i     (rf_we),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata)
	);

	decode_stage u_decode (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.advance_i    (advance),
		.instr_valid_i(instr_valid_i),
		.instr_i      (instr_i),
		.instr_ready_o(instr_ready_o),
		.raddr_a_o    (raddr_a),
		.raddr_b_o    (raddr_b),
		.rdata_a_i    (rdata_a),
		.rdata_b_i    (rdata_b),
		.ex_busy_i    (d2e_if),
		.mem_busy_i   (e2m_if),
		.wb_rd_i      (retire_rd_o),
		.wb_pending_i (retire_we_o),
		.out          (d2e_if)
	);

	execute_stage u_execute (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.advance_i(advance),
		.in       (d2e_if),
		.out      (e2m_if)
	);

	mem_stage #(
		.dmem_words(dmem_words)
	) u_mem (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.advance_i (advance),
		.in        (e2m_if),
		.out       (m2w_if),
		.io_sw_i   (io_sw_i),
		.io_ledr_o (io_ledr_o),
		.io_ledg_o (io_ledg_o),
		.io_hex_o  (io_hex_o),
		.ls_count_o(ls_count_o)
	);

	writeback_stage u_writeback (
		.in              (m2w_if),
		.retire_valid_o  (retire_valid_o),
		.retire_rd_o     (retire_rd_o),
		.retire_data_o   (retire_data_o),
		.retire_we_o     (retire_we_o),
		.retire_illegal_o(retire_illegal_o),
		.retire_ready_i  (retire_ready_i),
		.rf_we_o         (rf_we),
		.rf_waddr_o      (rf_waddr),
		.rf_wdata_o      (rf_wdata)
	);

endmodule

//--- logic/lsp_pkg.sv
package lsp_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	// operation picked by decode, carried down the pipe.
	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor,
		op_addi,
		op_lui,
		op_lw,
		op_sw,
		op_illegal
	} op_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_none
	} wb_sel_e;

	// rv32i major opcodes in use.
	localparam opcode_t opc_op     = 7'b0110011;
	localparam opcode_t opc_op_imm = 7'b0010011;
	localparam opcode_t opc_lui    = 7'b0110111;
	localparam opcode_t opc_load   = 7'b0000011;
	localparam opcode_t opc_store  = 7'b0100011;

	// memory mapped i/o.
	localparam word_t io_ledr_addr = 32'h1000_0000;
	localparam word_t io_ledg_addr = 32'h1000_0004;
	localparam word_t io_hex_addr  = 32'h1000_0008;
	localparam word_t io_sw_addr   = 32'h1000_0010;

	localparam int unsigned dmem_words_default = 256;

endpackage

//--- logic/lsu.sv
`timescale 1ns/1ns

module lsu #(
	parameter int unsigned dmem_words = lsp_pkg::dmem_words_default
) (
	input  logic           clk_i,
	input  logic           rst_ni,
	input  lsp_pkg::word_t addr_i,
	input  lsp_pkg::word_t wdata_i,
	input  logic           we_i,
	output lsp_pkg::word_t rdata_o,
	input  lsp_pkg::word_t io_sw_i,
	output lsp_pkg::word_t io_ledr_o,
	output lsp_pkg::word_t io_ledg_o,
	output lsp_pkg::word_t io_hex_o
);

	localparam int unsigned idx_w = $clog2(dmem_words);
	localparam lsp_pkg::word_t ram_limit = lsp_pkg::word_t'(dmem_words * 4);

	lsp_pkg::word_t ram [dmem_words];
	lsp_pkg::word_t ledr_r, ledg_r, hex_r;
	logic [idx_w-1:0] ram_idx;
	logic in_ram;

	assign in_ram  = (addr_i < ram_limit);
	assign ram_idx = addr_i[idx_w+1:2]; // low two bits ignored.

	always_comb begin
		if (in_ram) begin
			rdata_o = ram[ram_idx];
		end
		else begin
			case (addr_i)
				lsp_pkg::io_ledr_addr: rdata_o = ledr_r;
				lsp_pkg::io_ledg_addr: rdata_o = ledg_r;
				lsp_pkg::io_hex_addr:  rdata_o = hex_r;
				lsp_pkg::io_sw_addr:   rdata_o = io_sw_i;
				default:               rdata_o = '0; // unmapped.
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (we_i && in_ram) begin
			ram[ram_idx] <= wdata_i;
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (~rst_ni) begin
			ledr_r <= '0;
			ledg_r <= '0;
			hex_r  <= '0;
		end
		else if (we_i && !in_ram) begin
			case (addr_i)
				lsp_pkg::io_ledr_addr: ledr_r <= wdata_i;
				lsp_pkg::io_ledg_addr: ledg_r <= wdata_i;
				lsp_pkg::io_hex_addr:  hex_r  <= wdata_i;
				default: ;
			endcase
		end
	end

	assign io_ledr_o = ledr_r;
	assign io_ledg_o = ledg_r;
	assign io_hex_o  = hex_r;

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ns

module mem_stage #(
	parameter int unsigned dmem_words = lsp_pkg::dmem_words_default
) (
	input  logic           clk_i,
	input  logic           rst_ni,
	input  logic           advance_i,
	stage_if.dst           in,
	stage_if.src           out,
	input  lsp_pkg::word_t io_sw_i,
	output lsp_pkg::word_t io_ledr_o,
	output lsp_pkg::word_t io_ledg_o,
	output lsp_pkg::word_t io_hex_o,
	output lsp_pkg::word_t ls_count_o
);

	lsp_pkg::word_t load_data;
	lsp_pkg::word_t ls_count_r;
	logic store_en;
	logic is_ls;

	assign store_en = advance_i & in.valid & (in.op == lsp_pkg::op_sw);
	assign is_ls = in.valid & (in.op inside {lsp_pkg::op_lw, lsp_pkg::op_sw});

	lsu #(
		.dmem_words(dmem_words)
	) u_lsu (
		.clk_i    (clk_i),
		.rst_ni   (rst_ni),
		.addr_i   (in.a),
		.wdata_i  (in.store_data),
		.we_i     (store_en),
		.rdata_o  (load_data),
		.io_sw_i  (io_sw_i),
		.io_ledr_o(io_ledr_o),
		.io_ledg_o(io_ledg_o),
		.io_hex_o (io_hex_o)
	);

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (~rst_ni) begin
			out.valid  <= 1'b0;
			out.op     <= lsp_pkg::op_illegal;
			out.wb_sel <= lsp_pkg::wb_none;
			out.rd     <= '0;
			out.reg_we <= 1'b0;
			ls_count_r <= '0;
		end
		else if (advance_i) begin
			out.valid  <= in.valid;
			out.op     <= in.op;
			out.wb_sel <= in.wb_sel;
			out.rd     <= in.rd;
			out.reg_we <= in.reg_we;
			if (is_ls) ls_count_r <= ls_count_r + 32'd1;
		end
	end

	// alu value stays in a, load data goes to b.
	always_ff @(posedge clk_i) begin
		if (advance_i) begin
			out.a          <= in.a;
			out.b          <= load_data;
			out.store_data <= in.store_data;
		end
	end

	assign ls_count_o = ls_count_r;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  lsp_pkg::reg_idx_t raddr_a_i,
	input  lsp_pkg::reg_idx_t raddr_b_i,
	output lsp_pkg::word_t    rdata_a_o,
	output lsp_pkg::word_t    rdata_b_o,
	input  logic              we_i,
	input  lsp_pkg::reg_idx_t waddr_i,
	input  lsp_pkg::word_t    wdata_i
);

	lsp_pkg::word_t regs [32];

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (~rst_ni) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end
		else if (we_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 is hardwired.
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- logic/stage_if.sv
`timescale 1ns/1ns

interface stage_if;

	logic              valid;
	lsp_pkg::op_e      op;
	lsp_pkg::wb_sel_e  wb_sel;
	lsp_pkg::reg_idx_t rd;
	logic              reg_we;
	lsp_pkg::word_t    a; // operand a, later the alu result or address.
	lsp_pkg::word_t    b; // operand b, later the load data.
	lsp_pkg::word_t    store_data;

	modport src (
		output valid,
		output op,
		output wb_sel,
		output rd,
		output reg_we,
		output a,
		output b,
		output store_data
	);

	modport dst (
		input valid,
		input op,
		input wb_sel,
		input rd,
		input reg_we,
		input a,
		input b,
		input store_data
	);

endinterface

//--- logic/writeback_stage.sv
`timescale 1ns/1ns

module writeback_stage (
	stage_if.dst              in,
	output logic              retire_valid_o,
	output lsp_pkg::reg_idx_t retire_rd_o,
	output lsp_pkg::word_t    retire_data_o,
	output logic              retire_we_o,
	output logic              retire_illegal_o,
	input  logic              retire_ready_i,
	output logic              rf_we_o,
	output lsp_pkg::reg_idx_t rf_waddr_o,
	output lsp_pkg::word_t    rf_wdata_o
);

	always_comb begin
		case (in.wb_sel)
			lsp_pkg::wb_alu: retire_data_o = in.a;
			lsp_pkg::wb_mem: retire_data_o = in.b;
			default:         retire_data_o = '0;
		endcase
	end

	assign retire_valid_o   = in.valid;
	assign retire_rd_o      = in.rd;
	assign retire_we_o      = in.valid & in.reg_we;
	assign retire_illegal_o = in.valid & (in.op == lsp_pkg::op_illegal);

	// register file sees the write only once the retire is taken.
	assign rf_we_o    = retire_we_o & retire_ready_i & (in.rd != '0);
	assign rf_waddr_o = in.rd;
	assign rf_wdata_o = retire_data_o;

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top -f verilog.f

# a $fatal in the testbench gives a non-zero exit status.
./obj_dir/Vtb_top

//--- tests/tb_tasks.svh
task automatic stop_run();
	$display("TESTS FAILED");
	$fatal(1, "simulation stopped at the first failure");
endtask

task automatic check_word(input string what, input lsp_pkg::word_t got,
	input lsp_pkg::word_t want);
	if (got !== want) begin
		$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_reg(input string what, input lsp_pkg::reg_idx_t got,
	input lsp_pkg::reg_idx_t want);
	if (got !== want) begin
		$display("error at %0t ns: %s is x%0d, expected x%0d", $time, what, got, want);
		stop_run();
	end
endtask

task automatic check_flag(input string what, input logic got, input logic want);
	if (got !== want) begin
		$display("error at %0t ns: %s is %b, expected %b", $time, what, got, want);
		stop_run();
	end
endtask

function automatic lsp_pkg::word_t sext12(input logic [11:0] imm);
	return {{20{imm[11]}}, imm};
endfunction

function automatic lsp_pkg::word_t load_model(input lsp_pkg::word_t addr);
	if (addr < lsp_pkg::dmem_words_default * 4) begin
		return model_mem[addr[9:2]];
	end
	case (addr)
		lsp_pkg::io_ledr_addr: return model_ledr;
		lsp_pkg::io_ledg_addr: return model_ledg;
		lsp_pkg::io_hex_addr:  return model_hex;
		lsp_pkg::io_sw_addr:   return io_sw;
		default:               return '0;
	endcase
endfunction

task automatic store_model(input lsp_pkg::word_t addr, input lsp_pkg::word_t data);
	if (addr < lsp_pkg::dmem_words_default * 4) begin
		model_mem[addr[9:2]] = data;
	end
	else begin
		case (addr)
			lsp_pkg::io_ledr_addr: model_ledr = data;
			lsp_pkg::io_ledg_addr: model_ledg = data;
			lsp_pkg::io_hex_addr:  model_hex = data;
			default: ;
		endcase
	end
endtask

task automatic note_retire(input logic we, input logic illegal, input lsp_pkg::reg_idx_t rd,
	input lsp_pkg::word_t data);
	retire_exp_t e;
	e.we = we;
	e.illegal = illegal;
	e.rd = rd;
	e.data = data;
	exp_q.push_back(e);
	if (we && rd != '0) model_reg[rd] = data; // x0 stays zero.
endtask

task automatic alu_instr(input lsp_pkg::op_e op, input lsp_pkg::reg_idx_t rd,
	input lsp_pkg::reg_idx_t rs1, input lsp_pkg::reg_idx_t rs2);
	lsp_pkg::word_t res;
	logic [6:0] f7;
	logic [2:0] f3;
	f7 = 7'b0000000;
	case (op)
		lsp_pkg::op_sub: begin
			f7 = 7'b0100000;
			f3 = 3'b000;
			res = model_reg[rs1] - model_reg[rs2];
		end
		lsp_pkg::op_and: begin
			f3 = 3'b111;
			res = model_reg[rs1] & model_reg[rs2];
		end
		lsp_pkg::op_or: begin
			f3 = 3'b110;
			res = model_reg[rs1] | model_reg[rs2];
		end
		lsp_pkg::op_xor: begin
			f3 = 3'b100;
			res = model_reg[rs1] ^ model_reg[rs2];
		end
		default: begin
			f3 = 3'b000;
			res = model_reg[rs1] + model_reg[rs2];
		end
	endcase
	prog_q.push_back({f7, rs2, rs1, f3, rd, 7'b0110011});
	note_retire(1'b1, 1'b0, rd, res);
endtask

task automatic addi_instr(input lsp_pkg::reg_idx_t rd, input lsp_pkg::reg_idx_t rs1,
	input logic [11:0] imm);
	prog_q.push_back({imm, rs1, 3'b000, rd, 7'b0010011});
	note_retire(1'b1, 1'b0, rd, model_reg[rs1] + sext12(imm));
endtask

task automatic lui_instr(input lsp_pkg::reg_idx_t rd, input logic [19:0] imm);
	prog_q.push_back({imm, rd, 7'b0110111});
	note_retire(1'b1, 1'b0, rd, {imm, 12'h000});
endtask

task automatic lw_instr(input lsp_pkg::reg_idx_t rd, input lsp_pkg::reg_idx_t rs1,
	input logic [11:0] imm);
	prog_q.push_back({imm, rs1, 3'b010, rd, 7'b0000011});
	model_ls = model_ls + 32'd1;
	note_retire(1'b1, 1'b0, rd, load_model(model_reg[rs1] + sext12(imm)));
endtask

task automatic sw_instr(input lsp_pkg::reg_idx_t rs2, input lsp_pkg::reg_idx_t rs1,
	input logic [11:0] imm);
	prog_q.push_back({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
	model_ls = model_ls + 32'd1;
	store_model(model_reg[rs1] + sext12(imm), model_reg[rs2]);
	note_retire(1'b0, 1'b0, '0, '0);
endtask

task automatic raw_instr(input lsp_pkg::word_t word);
	prog_q.push_back(word);
	note_retire(1'b0, 1'b1, '0, '0);
endtask

// starts and ends 2 ns after a rising edge.
task automatic send_instr(input lsp_pkg::word_t word);
	int cycles;
	instr_valid = 1'b1;
	instr = word;
	cycles = 0;
	@(negedge clk);
	while (!instr_ready) begin
		cycles++;
		if (cycles > wait_limit) begin
			$display("timeout: instr_ready_o stayed low for instruction %h", word);
			stop_run();
		end
		@(negedge clk);
	end
	@(posedge clk);
	#2;
	instr_valid = 1'b0;
endtask

task automatic expect_retire(input bit gaps);
	retire_exp_t want;
	int gap;
	int cycles;
	logic held;
	lsp_pkg::word_t held_data;
	lsp_pkg::reg_idx_t held_rd;
	if (gaps) gap = int'($urandom_range(4, 0));
	else gap = 0;
	held = 1'b0;
	held_data = '0;
	held_rd = '0;
	if (gap > 0) begin
		retire_ready = 1'b0;
		repeat (gap) begin
			@(negedge clk);
			if (held) begin // a stalled retire must not move.
				check_flag("retire_valid_o while stalled", retire_valid, 1'b1);
				check_word("retire_data_o while stalled", retire_data, held_data);
				check_reg("retire_rd_o while stalled", retire_rd, held_rd);
			end
			held = retire_valid;
			held_data = retire_data;
			held_rd = retire_rd;
		end
		@(posedge clk);
		#2;
		retire_ready = 1'b1;
	end
	cycles = 0;
	@(negedge clk);
	while (!retire_valid) begin
		cycles++;
		if (cycles > wait_limit) begin
			$display("timeout: no retire arrived, %0d still expected", exp_q.size());
			stop_run();
		end
		@(negedge clk);
	end
	want = exp_q.pop_front();
	check_flag("retire_illegal_o", retire_illegal, want.illegal);
	check_flag("retire_we_o", retire_we, want.we);
	if (want.we) begin
		check_reg("retire_rd_o", retire_rd, want.rd);
		check_word("retire_data_o", retire_data, want.data);
	end
	@(posedge clk);
	#2;
endtask

task automatic run_program(input bit gaps);
	int n;
	n = prog_q.size();
	fork
		begin
			foreach (prog_q[i]) begin
				send_instr(prog_q[i]);
			end
		end
		begin
			for (int k = 0; k < n; k++) begin
				expect_retire(gaps);
			end
		end
	join
	prog_q.delete();
	check_word("ls_count_o", ls_count, model_ls);
	// the pipe is drained, so no further retire may show up.
	repeat (4) begin
		@(negedge clk);
		check_flag("retire_valid_o with nothing outstanding", retire_valid, 1'b0);
	end
	@(posedge clk);
	#2;
endtask

task automatic alu_results();
	lsp_pkg::word_t r1;
	lsp_pkg::word_t r2;
	r1 = $urandom();
	r2 = $urandom();
	lui_instr(5'd1, r1[31:12]);
	addi_instr(5'd1, 5'd1, r1[11:0]);
	lui_instr(5'd2, r2[31:12]);
	addi_instr(5'd2, 5'd2, r2[11:0]);
	alu_instr(lsp_pkg::op_add, 5'd3, 5'd1, 5'd2);
	alu_instr(lsp_pkg::op_sub, 5'd4, 5'd1, 5'd2);
	alu_instr(lsp_pkg::op_and, 5'd5, 5'd1, 5'd2);
	alu_instr(lsp_pkg::op_or, 5'd6, 5'd1, 5'd2);
	alu_instr(lsp_pkg::op_xor, 5'd7, 5'd1, 5'd2);
	run_program(1'b0);
endtask

task automatic dependent_chain();
	lsp_pkg::word_t r;
	r = $urandom();
	lui_instr(5'd8, r[31:12]);
	addi_instr(5'd8, 5'd8, r[11:0]);
	addi_instr(5'd9, 5'd8, 12'h123);
	alu_instr(lsp_pkg::op_add, 5'd10, 5'd9, 5'd8);
	alu_instr(lsp_pkg::op_sub, 5'd11, 5'd10, 5'd9);
	alu_instr(lsp_pkg::op_xor, 5'd12, 5'd11, 5'd10);
	alu_instr(lsp_pkg::op_and, 5'd13, 5'd12, 5'd11);
	alu_instr(lsp_pkg::op_or, 5'd14, 5'd13, 5'd12);
	addi_instr(5'd15, 5'd14, 12'hfff);
	run_program(1'b0);
endtask

task automatic data_memory();
	lsp_pkg::word_t r;
	logic [11:0] offs [4];
	offs[0] = 12'h040;
	offs[1] = 12'h104;
	offs[2] = 12'h3fc;
	offs[3] = 12'h200;
	for (int i = 0; i < 4; i++) begin
		r = $urandom();
		lui_instr(5'd16, r[31:12]);
		addi_instr(5'd16, 5'd16, r[11:0]);
		sw_instr(5'd16, 5'd0, offs[i]);
	end
	for (int i = 0; i < 4; i++) begin
		lw_instr(5'd17, 5'd0, offs[i]);
	end
	run_program(1'b0);
endtask

task automatic io_map();
	lsp_pkg::word_t r;
	r = $urandom();
	io_sw = $urandom();
	lui_instr(5'd5, 20'h10000); // base of the i/o window.
	lui_instr(5'd6, r[31:12]);
	addi_instr(5'd6, 5'd6, r[11:0]);
	addi_instr(5'd7, 5'd6, 12'h555);
	addi_instr(5'd8, 5'd6, 12'h0aa);
	sw_instr(5'd6, 5'd5, 12'h000);
	sw_instr(5'd7, 5'd5, 12'h004);
	sw_instr(5'd8, 5'd5, 12'h008);
	lw_instr(5'd9, 5'd5, 12'h010);
	lw_instr(5'd10, 5'd5, 12'h020);
	lw_instr(5'd11, 5'd5, 12'h000);
	lw_instr(5'd12, 5'd0, 12'h7fc); // between the ram and the i/o window.
	run_program(1'b0);
	check_word("io_ledr_o", io_ledr, model_ledr);
	check_word("io_ledg_o", io_ledg, model_ledg);
	check_word("io_hex_o", io_hex, model_hex);
endtask

task automatic back_pressure();
	lsp_pkg::word_t r;
	for (int rep = 0; rep < 3; rep++) begin
		r = $urandom();
		lui_instr(5'd20, r[31:12]);
		addi_instr(5'd21, 5'd20, r[11:0]);
		sw_instr(5'd21, 5'd0, 12'h080);
		lw_instr(5'd22, 5'd0, 12'h080);
		alu_instr(lsp_pkg::op_add, 5'd23, 5'd22, 5'd21);
		addi_instr(5'd24, 5'd0, r[23:12]);
		alu_instr(lsp_pkg::op_sub, 5'd25, 5'd24, 5'd23);
		sw_instr(5'd25, 5'd0, 12'h084);
		addi_instr(5'd27, 5'd0, 12'h001);
		addi_instr(5'd28, 5'd0, 12'h002);
		addi_instr(5'd29, 5'd0, 12'h003);
		lw_instr(5'd26, 5'd0, 12'h084);
		run_program(1'b1);
	end
endtask

task automatic counter_and_illegal();
	addi_instr(5'd31, 5'd0, 12'h321);
	raw_instr(32'h0000_0fff);
	raw_instr({7'b0000001, 5'd2, 5'd1, 3'b000, 5'd31, 7'b0110011}); // mul.
	raw_instr({12'h000, 5'd0, 3'b000, 5'd31, 7'b0000011}); // byte load.
	addi_instr(5'd30, 5'd31, 12'h000);
	sw_instr(5'd30, 5'd0, 12'h010);
	lw_instr(5'd18, 5'd0, 12'h010);
	run_program(1'b0);
endtask

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top;

	localparam int wait_limit = 64;

	typedef struct packed {
		logic              we;
		logic              illegal;
		lsp_pkg::reg_idx_t rd;
		lsp_pkg::word_t    data;
	} retire_exp_t;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	lsp_pkg::word_t    instr;
	logic              instr_ready;
	logic              retire_valid;
	logic              retire_ready;
	lsp_pkg::reg_idx_t retire_rd;
	lsp_pkg::word_t    retire_data;
	logic              retire_we;
	logic              retire_illegal;
	lsp_pkg::word_t    io_sw;
	lsp_pkg::word_t    io_ledr;
	lsp_pkg::word_t    io_ledg;
	lsp_pkg::word_t    io_hex;
	lsp_pkg::word_t    ls_count;

	// reference model state follows program order as instructions are queued.
	lsp_pkg::word_t model_reg [32];
	lsp_pkg::word_t model_mem [lsp_pkg::dmem_words_default];
	lsp_pkg::word_t model_ledr;
	lsp_pkg::word_t model_ledg;
	lsp_pkg::word_t model_hex;
	lsp_pkg::word_t model_ls;
	lsp_pkg::word_t prog_q [$];
	retire_exp_t exp_q [$];

	ls_core_top dut0 (
		.clk_i           (clk),
		.rst_ni          (rst_n),
		.instr_valid_i   (instr_valid),
		.instr_i         (instr),
		.instr_ready_o   (instr_ready),
		.retire_valid_o  (retire_valid),
		.retire_ready_i  (retire_ready),
		.retire_rd_o     (retire_rd),
		.retire_data_o   (retire_data),
		.retire_we_o     (retire_we),
		.retire_illegal_o(retire_illegal),
		.io_sw_i         (io_sw),
		.io_ledr_o       (io_ledr),
		.io_ledg_o       (io_ledg),
		.io_hex_o        (io_hex),
		.ls_count_o      (ls_count)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	`include "tb_tasks.svh"

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		retire_ready = 1'b1;
		io_sw = '0;
		rst_n = 1'b0;
		void'($urandom(55732));
		for (int i = 0; i < 32; i++) begin
			model_reg[i] = '0;
		end
		model_ledr = '0;
		model_ledg = '0;
		model_hex = '0;
		model_ls = '0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// state right after reset.
		@(negedge clk);
		check_flag("instr_ready_o", instr_ready, 1'b1);
		check_flag("retire_valid_o", retire_valid, 1'b0);
		check_word("io_ledr_o", io_ledr, '0);
		check_word("io_ledg_o", io_ledg, '0);
		check_word("io_hex_o", io_hex, '0);
		check_word("ls_count_o", ls_count, '0);
		@(posedge clk);
		#2;

		alu_results();
		dependent_chain();
		data_memory();
		io_map();
		back_pressure();
		counter_and_illegal();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- verilog.f
logic/lsp_pkg.sv
logic/stage_if.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/lsu.sv
logic/mem_stage.sv
logic/writeback_stage.sv
logic/ls_core_top.sv
+incdir+tests
tests/tb_top.sv
